/* verilog/ppi_pkg.sv */
package ppi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths

    localparam int AW = 32;
    localparam int DW = 32;
    localparam int MW = DW / 8;

    ////////////////////////////////////////////////////////////////////////////
    // ports

    localparam int TGT_NUM   = 4;
    localparam int PORT_NUM  = TGT_NUM + 1;

    // target order on every per-target vector
    localparam int TGT_GPIOA = 0;
    localparam int TGT_UART  = 1;
    localparam int TGT_TIMER = 2;
    localparam int TGT_GPU   = 3;
    localparam int MISS_PORT = TGT_NUM;

    ////////////////////////////////////////////////////////////////////////////
    // address map, compared on 4 KiB pages

    localparam int PAGE_LSB     = 12;
    localparam int PAGE_W       = AW - PAGE_LSB;
    localparam int GPU_WIN1_LSB = 16;
    localparam int GPU_WIN1_W   = AW - GPU_WIN1_LSB;

    localparam logic [PAGE_W-1:0] GPIOA_PAGE    = 20'h10012;
    localparam logic [PAGE_W-1:0] UART_PAGE_LO  = 20'h10013;
    localparam logic [PAGE_W-1:0] UART_PAGE_HI  = 20'h10014;
    localparam logic [PAGE_W-1:0] TIMER_PAGE_LO = 20'h10015;
    localparam logic [PAGE_W-1:0] TIMER_PAGE_HI = 20'h10016;

    // gpu owns a 64 KiB window plus one extra page
    localparam logic [GPU_WIN1_W-1:0] GPU_WIN1 = 16'h1003;
    localparam logic [PAGE_W-1:0]     GPU_WIN2 = 20'h10020;

    ////////////////////////////////////////////////////////////////////////////
    // payloads

    // one bit per port, miss port on top
    typedef logic [PORT_NUM-1:0] port_sel_t;

    typedef struct packed {
        logic [AW-1:0] addr;
        logic          read;
        logic [DW-1:0] wdata;
        logic [MW-1:0] wmask;
        logic [1:0]    size;
    } icb_cmd_t;

    typedef struct packed {
        logic          err;
        logic [DW-1:0] rdata;
    } icb_rsp_t;

endpackage

/* verilog/ppi_cmd_buffer.sv */
`timescale 1ns/1ps

module ppi_cmd_buffer import ppi_pkg::*; #(
    parameter int BUF_DP = 2
) (
    input  logic     deft_icb_cmd_valid,
    input  logic     i_arst_n,

    // upstream
    input  logic     i_valid,
    output logic     o_ready,
    input  icb_cmd_t i_cmd,

    // downstream
    output logic     o_valid,
    input  logic     i_ready,
    output icb_cmd_t o_cmd
);

    generate
        if (BUF_DP == 0) begin : g_bypass

            assign o_valid = i_valid;
            assign o_ready = i_ready;
            assign o_cmd   = i_cmd;

        end else begin : g_pingpong

            icb_cmd_t   slot_q [2];
            logic [1:0] busy_q;
            logic       wptr_q;
            logic       rptr_q;
            logic       wr_en;
            logic       rd_en;

            // ready only looks at local occupancy
            assign o_ready = ~&busy_q;
            assign o_valid = busy_q[rptr_q];
            assign o_cmd   = slot_q[rptr_q];

            assign wr_en = i_valid & o_ready;
            assign rd_en = o_valid & i_ready;

            always_ff @(posedge deft_icb_cmd_valid or negedge i_arst_n) begin
                if (!i_arst_n) begin
                    busy_q <= '0;
                    wptr_q <= 1'b0;
                    rptr_q <= 1'b0;
                end else begin
                    if (wr_en) begin
                        busy_q[wptr_q] <= 1'b1;
                        wptr_q         <= ~wptr_q;
                    end
                    if (rd_en) begin
                        busy_q[rptr_q] <= 1'b0;
                        rptr_q         <= ~rptr_q;
                    end
                end
            end

            always_ff @(posedge deft_icb_cmd_valid) begin
                if (wr_en) begin
                    slot_q[wptr_q] <= i_cmd;
                end
            end

            // the write pointer never lands on a slot still waiting to drain
            a_no_overwrite: assert property (
                @(posedge deft_icb_cmd_valid) disable iff (!i_arst_n)
                wr_en |-> !busy_q[wptr_q]
            );

        end
    endgenerate

endmodule

/* verilog/ppi_addr_decode.sv */
`timescale 1ns/1ps

module ppi_addr_decode import ppi_pkg::*; (
    input  logic [AW-1:0]      i_addr,
    input  logic [TGT_NUM-1:0] i_tgt_en,
    output port_sel_t          o_sel
);

    logic [PAGE_W-1:0]     page;
    logic [GPU_WIN1_W-1:0] win;
    logic [TGT_NUM-1:0]    hit;
    logic [TGT_NUM-1:0]    hit_en;

    assign page = i_addr[AW-1:PAGE_LSB];
    assign win  = i_addr[AW-1:GPU_WIN1_LSB];

    ////////////////////////////////////////////////////////////////////////////
    // region match

    assign hit[TGT_GPIOA] = (page == GPIOA_PAGE);

    assign hit[TGT_UART]  = (page >= UART_PAGE_LO) && (page <= UART_PAGE_HI);

    assign hit[TGT_TIMER] = (page >= TIMER_PAGE_LO) && (page <= TIMER_PAGE_HI);

    assign hit[TGT_GPU]   = (win == GPU_WIN1) || (page == GPU_WIN2);

    ////////////////////////////////////////////////////////////////////////////
    // enable mask and miss

    // regions are disjoint, so at most one hit survives
    assign hit_en = hit & i_tgt_en;

    assign o_sel = {~|hit_en, hit_en};

endmodule

/* verilog/ppi_icb_splitter.sv */
`timescale 1ns/1ps

module ppi_icb_splitter import ppi_pkg::*; #(
    parameter int OUTS_NUM = 2
) (
    input  logic               deft_icb_cmd_valid,
    input  logic               i_arst_n,

    // command from the buffer
    input  logic               i_cmd_valid,
    output logic               o_cmd_ready,
    input  icb_cmd_t           i_cmd,
    input  port_sel_t          i_sel,

    // target side
    output logic [TGT_NUM-1:0] o_tgt_cmd_valid,
    input  logic [TGT_NUM-1:0] i_tgt_cmd_ready,
    output icb_cmd_t           o_tgt_cmd,
    input  logic [TGT_NUM-1:0] i_tgt_rsp_valid,
    output logic [TGT_NUM-1:0] o_tgt_rsp_ready,
    input  icb_rsp_t           i_tgt_rsp [TGT_NUM],

    // response to the initiator
    output logic               o_rsp_valid,
    input  logic               i_rsp_ready,
    output icb_rsp_t           o_rsp
);

    localparam int PTR_W = (OUTS_NUM > 1) ? $clog2(OUTS_NUM) : 1;
    localparam int CNT_W = $clog2(OUTS_NUM + 1);

    port_sel_t        ord_q [OUTS_NUM];
    logic [PTR_W-1:0] wptr_q;
    logic [PTR_W-1:0] rptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             fifo_full;
    logic             fifo_empty;
    logic             push;
    logic             pop;
    port_sel_t        head;
    port_sel_t        port_rdy;
    port_sel_t        port_vld;
    port_sel_t        rsp_vld;
    logic             miss_cmd_valid;
    logic             miss_rsp_valid;
    icb_rsp_t         rsp_mux;

    assign fifo_full  = (cnt_q == CNT_W'(OUTS_NUM));
    assign fifo_empty = (cnt_q == '0);
    assign head       = ord_q[rptr_q];

    ////////////////////////////////////////////////////////////////////////////
    // command steering

    assign port_rdy = {1'b1, i_tgt_cmd_ready};

    assign o_tgt_cmd_valid = i_sel[TGT_NUM-1:0] & {TGT_NUM{i_cmd_valid & ~fifo_full}};
    assign miss_cmd_valid  = i_sel[MISS_PORT] & i_cmd_valid & ~fifo_full;
    assign o_tgt_cmd       = i_cmd;

    assign port_vld    = {miss_cmd_valid, o_tgt_cmd_valid};
    assign o_cmd_ready = ~fifo_full & |(i_sel & port_rdy);
    assign push        = |(port_vld & port_rdy);

    ////////////////////////////////////////////////////////////////////////////
    // order fifo

    always_ff @(posedge deft_icb_cmd_valid or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (push) begin
                wptr_q <= (wptr_q == PTR_W'(OUTS_NUM - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == PTR_W'(OUTS_NUM - 1)) ? '0 : rptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge deft_icb_cmd_valid) begin
        if (push) begin
            ord_q[wptr_q] <= i_sel;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response return from the head port only

    // miss responder answers as soon as its entry reaches the head
    assign miss_rsp_valid = ~fifo_empty & head[MISS_PORT];

    assign rsp_vld = {miss_rsp_valid, i_tgt_rsp_valid};

    assign o_rsp_valid     = ~fifo_empty & |(head & rsp_vld);
    assign o_tgt_rsp_ready = head[TGT_NUM-1:0] & {TGT_NUM{~fifo_empty & i_rsp_ready}};
    assign pop             = o_rsp_valid & i_rsp_ready;

    always_comb begin
        rsp_mux = '0;
        for (int i = 0; i < TGT_NUM; i++) begin
            if (head[i]) begin
                rsp_mux = i_tgt_rsp[i];
            end
        end
        if (head[MISS_PORT]) begin
            rsp_mux = '{err: 1'b1, rdata: '0};
        end
    end

    assign o_rsp = rsp_mux;

    // decoder output must pick exactly one port
    a_sel_onehot: assert property (
        @(posedge deft_icb_cmd_valid) disable iff (!i_arst_n)
        i_cmd_valid |-> $onehot(i_sel)
    );

    // pointers alone must show an entry to pop
    a_no_pop_empty: assert property (
        @(posedge deft_icb_cmd_valid) disable iff (!i_arst_n)
        pop |-> (wptr_q != rptr_q) || fifo_full
    );

endmodule

/* verilog/ppi_bridge.sv */
`timescale 1ns/1ps

module ppi_bridge import ppi_pkg::*; #(
    parameter int BUF_DP   = 2,
    parameter int OUTS_NUM = 2
) (
    input  logic               deft_icb_cmd_valid,
    input  logic               i_arst_n,

    // initiator port
    input  logic               i_cmd_valid,
    output logic               o_cmd_ready,
    input  icb_cmd_t           i_cmd,
    output logic               o_rsp_valid,
    input  logic               i_rsp_ready,
    output icb_rsp_t           o_rsp,

    // target ports
    input  logic [TGT_NUM-1:0] i_tgt_en,
    output logic [TGT_NUM-1:0] o_tgt_cmd_valid,
    input  logic [TGT_NUM-1:0] i_tgt_cmd_ready,
    output icb_cmd_t           o_tgt_cmd,
    input  logic [TGT_NUM-1:0] i_tgt_rsp_valid,
    output logic [TGT_NUM-1:0] o_tgt_rsp_ready,
    input  icb_rsp_t           i_tgt_rsp [TGT_NUM]
);

    logic      buf_cmd_valid;
    logic      buf_cmd_ready;
    icb_cmd_t  buf_cmd;
    port_sel_t port_sel;

    ppi_cmd_buffer #(
        .BUF_DP (BUF_DP)
    ) u_cmd_buffer (
        .deft_icb_cmd_valid (deft_icb_cmd_valid),
        .i_arst_n           (i_arst_n),
        .i_valid            (i_cmd_valid),
        .o_ready            (o_cmd_ready),
        .i_cmd              (i_cmd),
        .o_valid            (buf_cmd_valid),
        .i_ready            (buf_cmd_ready),
        .o_cmd              (buf_cmd)
    );

    ppi_addr_decode u_addr_decode (
        .i_addr   (buf_cmd.addr),
        .i_tgt_en (i_tgt_en),
        .o_sel    (port_sel)
    );

    ppi_icb_splitter #(
        .OUTS_NUM (OUTS_NUM)
    ) u_splitter (
        .deft_icb_cmd_valid (deft_icb_cmd_valid),
        .i_arst_n           (i_arst_n),
        .i_cmd_valid        (buf_cmd_valid),
        .o_cmd_ready        (buf_cmd_ready),
        .i_cmd              (buf_cmd),
        .i_sel              (port_sel),
        .o_tgt_cmd_valid    (o_tgt_cmd_valid),
        .i_tgt_cmd_ready    (i_tgt_cmd_ready),
        .o_tgt_cmd          (o_tgt_cmd),
        .i_tgt_rsp_valid    (i_tgt_rsp_valid),
        .o_tgt_rsp_ready    (o_tgt_rsp_ready),
        .i_tgt_rsp          (i_tgt_rsp),
        .o_rsp_valid        (o_rsp_valid),
        .i_rsp_ready        (i_rsp_ready),
        .o_rsp              (o_rsp)
    );

endmodule

/* testbench/tb_ppi_target.sv */
`timescale 1ns/1ps

module tb_ppi_target
    import ppi_pkg::*;
#(
    parameter int IDX = 0
) (
    input  logic     deft_icb_cmd_valid,
    input  logic     i_arst_n,
    input  logic     i_cmd_valid,
    output logic     o_cmd_ready,
    input  icb_cmd_t i_cmd,
    output logic     o_rsp_valid,
    input  logic     i_rsp_ready,
    output icb_rsp_t o_rsp,
    output logic     o_hang
);

    localparam int HANG_LIMIT = 1000;

    // 16-bit fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        logic [15:0]   lfsr;
        logic [AW-1:0] addr;
        int            delay;
        int            waited;
        int            b;
        lfsr        = 16'd64453;
        o_cmd_ready = 1'b0;
        o_rsp_valid = 1'b0;
        o_rsp       = '0;
        o_hang      = 1'b0;
        forever begin
            @(negedge deft_icb_cmd_valid);
            o_rsp_valid = 1'b0;
            o_cmd_ready = i_arst_n;
            @(posedge deft_icb_cmd_valid);
            if (i_cmd_valid && o_cmd_ready) begin
                addr  = i_cmd.addr;
                delay = 1;
                // one lfsr step per delay bit
                for (b = 0; b < 2; b++) begin
                    lfsr  = lfsr_next(lfsr);
                    delay = delay + (int'(lfsr[0]) << b);
                end
                @(negedge deft_icb_cmd_valid);
                o_cmd_ready = 1'b0;
                repeat (delay - 1) @(negedge deft_icb_cmd_valid);
                o_rsp_valid = 1'b1;
                o_rsp       = '{err: 1'b0, rdata: addr + AW'(IDX)};
                waited      = 0;
                do begin
                    @(posedge deft_icb_cmd_valid);
                    waited++;
                end while (!i_rsp_ready && waited < HANG_LIMIT);
                if (!i_rsp_ready) begin
                    $display("target %0d never saw response ready", IDX);
                    o_hang = 1'b1;
                end
            end
        end
    end

endmodule

/* testbench/tb_ppi_bridge.sv */
`timescale 1ns/1ps

module tb_ppi_bridge
    import ppi_pkg::*;
();

    localparam int MAX_TX  = 32;
    localparam int COLS    = 7;
    localparam int TIMEOUT = 500;

    logic               deft_icb_cmd_valid;
    logic               arst_n;
    logic               cmd_valid;
    logic               cmd_ready;
    icb_cmd_t           cmd;
    logic               rsp_valid;
    logic               rsp_ready;
    icb_rsp_t           rsp;
    logic [TGT_NUM-1:0] tgt_en;
    logic [TGT_NUM-1:0] tgt_cmd_valid;
    logic [TGT_NUM-1:0] tgt_cmd_ready;
    icb_cmd_t           tgt_cmd;
    logic [TGT_NUM-1:0] tgt_rsp_valid;
    logic [TGT_NUM-1:0] tgt_rsp_ready;
    icb_rsp_t           tgt_rsp [TGT_NUM];
    logic [TGT_NUM-1:0] tgt_hang;

    // seven words per row from the data file
    logic [31:0]        vec [MAX_TX*COLS];
    icb_rsp_t           exp_q [$];
    icb_cmd_t           tgt_exp_q [$];
    logic [15:0]        stall_lfsr;
    int                 err_cnt;
    int                 err_base;
    int                 test_cnt;
    int                 fail_cnt;

    initial deft_icb_cmd_valid = 1'b0;
    always #2 deft_icb_cmd_valid = ~deft_icb_cmd_valid;

    ppi_bridge #(
        .BUF_DP   (2),
        .OUTS_NUM (2)
    ) u_ppi_bridge (
        .deft_icb_cmd_valid (deft_icb_cmd_valid),
        .i_arst_n           (arst_n),
        .i_cmd_valid        (cmd_valid),
        .o_cmd_ready        (cmd_ready),
        .i_cmd              (cmd),
        .o_rsp_valid        (rsp_valid),
        .i_rsp_ready        (rsp_ready),
        .o_rsp              (rsp),
        .i_tgt_en           (tgt_en),
        .o_tgt_cmd_valid    (tgt_cmd_valid),
        .i_tgt_cmd_ready    (tgt_cmd_ready),
        .o_tgt_cmd          (tgt_cmd),
        .i_tgt_rsp_valid    (tgt_rsp_valid),
        .o_tgt_rsp_ready    (tgt_rsp_ready),
        .i_tgt_rsp          (tgt_rsp)
    );

    for (genvar g = 0; g < TGT_NUM; g++) begin : g_tgt
        tb_ppi_target #(
            .IDX (g)
        ) u_tgt (
            .deft_icb_cmd_valid (deft_icb_cmd_valid),
            .i_arst_n           (arst_n),
            .i_cmd_valid        (tgt_cmd_valid[g]),
            .o_cmd_ready        (tgt_cmd_ready[g]),
            .i_cmd              (tgt_cmd),
            .o_rsp_valid        (tgt_rsp_valid[g]),
            .i_rsp_ready        (tgt_rsp_ready[g]),
            .o_rsp              (tgt_rsp[g]),
            .o_hang             (tgt_hang[g])
        );
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic bit row_valid(input int row);
        return row < MAX_TX && !$isunknown(vec[row*COLS]) && vec[row*COLS] != 0;
    endfunction

    task automatic check_equal(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input int num);
        test_cnt++;
        if (err_cnt == err_base) begin
            $display("test %0d done, ok", num);
        end else begin
            fail_cnt++;
            $display("test %0d done, %0d errors", num, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // initiator driver

    task automatic drive_commands(input int first, input int last);
        int n;
        int base;
        int t;
        for (n = first; n < last; n++) begin
            base = n * COLS;
            // enables only change while the bridge is idle
            if (tgt_en != vec[base+4][TGT_NUM-1:0]) begin
                t = 0;
                while (exp_q.size() != 0 && t < TIMEOUT) begin
                    @(negedge deft_icb_cmd_valid);
                    t++;
                end
                if (exp_q.size() != 0) begin
                    $display("bridge did not drain before enable change in test %0d", vec[base]);
                    err_cnt++;
                end
                tgt_en = vec[base+4][TGT_NUM-1:0];
            end
            cmd_valid = 1'b1;
            cmd.addr  = vec[base+2];
            cmd.read  = vec[base+1][0];
            cmd.wdata = vec[base+3];
            cmd.wmask = vec[base+1][0] ? '0 : '1;
            cmd.size  = 2'd2;
            t = 0;
            do begin
                @(posedge deft_icb_cmd_valid);
                t++;
            end while (!cmd_ready && t < TIMEOUT);
            if (cmd_ready) begin
                exp_q.push_back('{err: vec[base+5][0], rdata: vec[base+6]});
                // only commands that hit an enabled target reach one
                if (!vec[base+5][0]) begin
                    tgt_exp_q.push_back(cmd);
                end
            end else begin
                $display("command ready never came in test %0d", vec[base]);
                err_cnt++;
            end
            @(negedge deft_icb_cmd_valid);
            cmd_valid = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // response checker

    task automatic collect_responses(input int count);
        int       n;
        int       t;
        icb_rsp_t exp;
        for (n = 0; n < count; n++) begin
            t = 0;
            do begin
                @(negedge deft_icb_cmd_valid);
                stall_lfsr = lfsr_next(stall_lfsr);
                rsp_ready  = stall_lfsr[0];
                @(posedge deft_icb_cmd_valid);
                t++;
            end while (!(rsp_valid && rsp_ready) && t < TIMEOUT);
            if (!(rsp_valid && rsp_ready)) begin
                $display("no response arrived for transaction %0d of %0d", n + 1, count);
                err_cnt++;
            end else if (exp_q.size() == 0) begin
                $display("response arrived with no command outstanding");
                err_cnt++;
            end else begin
                exp = exp_q.pop_front();
                check_equal(DW'(rsp.err), DW'(exp.err), "response err");
                check_equal(rsp.rdata, exp.rdata, "response rdata");
            end
        end
    endtask

    // disabled targets must never see a command
    // and every target command carries the payload as sent
    always @(posedge deft_icb_cmd_valid) begin : target_monitor
        icb_cmd_t exp_cmd;
        if (arst_n) begin
            check_equal(DW'(tgt_cmd_valid & ~tgt_en), '0, "command to disabled target");
            if (|(tgt_cmd_valid & tgt_cmd_ready)) begin
                if (tgt_exp_q.size() == 0) begin
                    $display("a target accepted a command that no target should get");
                    err_cnt++;
                end else begin
                    exp_cmd = tgt_exp_q.pop_front();
                    check_equal(tgt_cmd.addr, exp_cmd.addr, "target cmd addr");
                    check_equal(tgt_cmd.wdata, exp_cmd.wdata, "target cmd wdata");
                    check_equal(DW'({tgt_cmd.read, tgt_cmd.wmask, tgt_cmd.size}),
                                DW'({exp_cmd.read, exp_cmd.wmask, exp_cmd.size}),
                                "target cmd read wmask size");
                end
            end
        end
    end

    initial begin
        int row;
        int last;
        int tnum;
        arst_n     = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        rsp_ready  = 1'b0;
        tgt_en     = '1;
        stall_lfsr = 16'd64453;
        err_cnt    = 0;
        err_base   = 0;
        test_cnt   = 0;
        fail_cnt   = 0;
        $readmemh("testbench/ppi_bridge_input.txt", vec);
        repeat (10) @(negedge deft_icb_cmd_valid);
        arst_n = 1'b1;
        @(negedge deft_icb_cmd_valid);

        // idle state out of reset
        check_equal(DW'(rsp_valid), '0, "rsp valid after reset");
        check_equal(DW'(tgt_cmd_valid), '0, "target cmd valid after reset");
        check_equal(DW'(cmd_ready), 1, "cmd ready after reset");
        report_test(1);

        row = 0;
        while (row_valid(row)) begin
            tnum = vec[row*COLS];
            last = row;
            while (row_valid(last) && vec[last*COLS] == tnum) begin
                last++;
            end
            @(negedge deft_icb_cmd_valid);
            fork
                drive_commands(row, last);
                collect_responses(last - row);
            join
            report_test(tnum);
            row = last;
        end

        if (|tgt_hang) begin
            $display("a target model gave up waiting for response ready");
            err_cnt++;
        end
        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/ppi_bridge_input.txt */
// test read addr wdata en_mask exp_err exp_rdata, all hex
// rdata from a target is addr plus its index (gpioa 0, uart 1, timer 2, gpu 3)
02 1 10012004 00000000 f 0 10012004
02 1 10013000 00000000 f 0 10013001
02 1 10014ffc 00000000 f 0 10014ffd
02 1 10015010 00000000 f 0 10015012
02 1 10016ff0 00000000 f 0 10016ff2
02 1 10030000 00000000 f 0 10030003
02 1 1003fff8 00000000 f 0 1003fffb
02 1 10020040 00000000 f 0 10020043
03 1 10011ffc 00000000 f 1 00000000
03 1 10017000 00000000 f 1 00000000
03 1 10021000 00000000 f 1 00000000
04 1 10012010 00000000 e 1 00000000
04 1 10013020 00000000 d 1 00000000
04 1 10016000 00000000 b 1 00000000
04 1 1002000c 00000000 7 1 00000000
05 0 10012100 deadbeef f 0 10012100
05 1 10013200 00000000 f 0 10013201
05 1 10040000 00000000 f 1 00000000
05 0 10015300 12345678 f 0 10015302
05 1 10031000 00000000 f 0 10031003
05 0 00001000 a5a5a5a5 f 1 00000000
05 1 10020ffc 00000000 f 0 10020fff
05 0 10014000 0f0f0f0f f 0 10014001
05 1 10016abc 00000000 f 0 10016abe

/* ppi_bridge.f */
verilog/ppi_pkg.sv
verilog/ppi_cmd_buffer.sv
verilog/ppi_addr_decode.sv
verilog/ppi_icb_splitter.sv
verilog/ppi_bridge.sv
testbench/tb_ppi_target.sv
testbench/tb_ppi_bridge.sv

/* Bender.yml */
package:
  name: ppi_bridge

sources:
  - files:
      - verilog/ppi_pkg.sv
      - verilog/ppi_cmd_buffer.sv
      - verilog/ppi_addr_decode.sv
      - verilog/ppi_icb_splitter.sv
      - verilog/ppi_bridge.sv
  - target: test
    files:
      - testbench/tb_ppi_target.sv
      - testbench/tb_ppi_bridge.sv
